// File: design/egress_demux.sv
// Egress input demux

`timescale 1ns/1ns

module egress_demux
    import egress_pkg::*;
(
    input  logic                      egr_bus,
    input  logic                      rst,
    input  logic                      egr_tvalid,
    input  logic [EGR_DATA_WIDTH-1:0] egr_tdata,
    input  logic [EGR_DATA_BYTES-1:0] egr_tkeep,
    input  logic                      egr_tlast,
    input  logic [PORT_SEL_WIDTH-1:0] egr_tuser,
    output logic                      egr_tready,
    output logic [NUM_EGR_PORTS-1:0]  dmx_valid,
    output logic                      dmx_first,
    output logic [EGR_DATA_WIDTH-1:0] dmx_data,
    output logic [EGR_DATA_BYTES-1:0] dmx_keep,
    output logic                      dmx_last
);

    logic                      in_pkt;
    logic [PORT_SEL_WIDTH-1:0] sel_q;
    logic [PORT_SEL_WIDTH-1:0] cur_sel;
    logic                      beat_ok;

    assign beat_ok = egr_tvalid && egr_tready;
    // Port field only counts on the first beat
    assign cur_sel = in_pkt ? sel_q : egr_tuser;

    always_ff @(posedge egr_bus) begin
        if (rst) begin
            egr_tready <= 1'b0;
            in_pkt     <= 1'b0;
            sel_q      <= '0;
            dmx_valid  <= '0;
            dmx_first  <= 1'b0;
        end else begin
            egr_tready <= 1'b1;
            dmx_first  <= beat_ok && !in_pkt;
            if (beat_ok) begin
                in_pkt <= !egr_tlast;
                sel_q  <= cur_sel;
            end
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                dmx_valid[p] <= beat_ok && (cur_sel == PORT_SEL_WIDTH'(p));
            end
        end
    end

    // Beat goes to every port, only one valid is raised
    always_ff @(posedge egr_bus) begin
        if (beat_ok) begin
            dmx_data <= egr_tdata;
            dmx_keep <= egr_tkeep;
            dmx_last <= egr_tlast;
        end
    end

endmodule

// File: design/egress_pkg.sv
// Egress stage shared constants

package egress_pkg;

    //////////////////////////////////////////////////
    // Wide input bus
    localparam int EGR_DATA_BYTES = 8;
    localparam int EGR_DATA_WIDTH = EGR_DATA_BYTES * 8;

    // Physical port word
    localparam int PORT_DATA_BYTES = 2;
    localparam int PORT_DATA_WIDTH = PORT_DATA_BYTES * 8;
    localparam int WORDS_PER_BEAT  = EGR_DATA_BYTES / PORT_DATA_BYTES;
    localparam int WORD_CNT_WIDTH  = $clog2(WORDS_PER_BEAT + 1);

    //////////////////////////////////////////////////
    // Port selection carried in tuser
    localparam int NUM_EGR_PORTS  = 4;
    localparam int PORT_SEL_WIDTH = $clog2(NUM_EGR_PORTS);

    // Per-port beat buffer
    localparam int BUF_DEPTH      = 32;
    localparam int BUF_ADDR_WIDTH = $clog2(BUF_DEPTH);

    // Largest packet the input may send, in beats
    localparam int MTU_BEATS       = 8;
    localparam int PKT_BYTES_WIDTH = $clog2(MTU_BEATS * EGR_DATA_BYTES + 1);

    //////////////////////////////////////////////////
    // Statistics counters
    localparam int NUM_EGR_CNTS      = 4;
    localparam int CNT_PKTS_SENT     = 0;
    localparam int CNT_BYTES_SENT    = 1;
    localparam int CNT_DROP_FULL     = 2;
    localparam int CNT_DROP_DISABLED = 3;
    localparam int EGR_CNT_WIDTH     = 32;

endpackage

// File: design/egress_port_buffer.sv
// Per-port packet buffer
// Whole packets are admitted or dropped on their first beat

`timescale 1ns/1ns

module egress_port_buffer
    import egress_pkg::*;
(
    input  logic                       egr_bus,
    input  logic                       rst,
    input  logic                       port_enable,
    input  logic                       dmx_valid,
    input  logic                       dmx_first,
    input  logic [EGR_DATA_WIDTH-1:0]  dmx_data,
    input  logic [EGR_DATA_BYTES-1:0]  dmx_keep,
    input  logic                       dmx_last,
    input  logic                       buf_pop,
    output logic                       buf_empty,
    output logic [EGR_DATA_WIDTH-1:0]  buf_data,
    output logic [EGR_DATA_BYTES-1:0]  buf_keep,
    output logic                       buf_last,
    output logic                       evt_sent,
    output logic [PKT_BYTES_WIDTH-1:0] evt_bytes,
    output logic                       evt_drop_full,
    output logic                       evt_drop_disabled,
    output logic                       buf_full_drop
);

    logic [EGR_DATA_WIDTH-1:0]  mem_data [BUF_DEPTH];
    logic [EGR_DATA_BYTES-1:0]  mem_keep [BUF_DEPTH];
    logic                       mem_last [BUF_DEPTH];
    logic [BUF_ADDR_WIDTH-1:0]  wr_ptr;
    logic [BUF_ADDR_WIDTH-1:0]  rd_ptr;
    logic [BUF_ADDR_WIDTH:0]    count;
    logic [BUF_ADDR_WIDTH:0]    free_cnt;
    logic                       room_ok;
    logic                       dropping;
    logic                       drop_now;
    logic                       wr_en;
    logic                       rd_en;
    logic [PKT_BYTES_WIDTH-1:0] beat_bytes;
    logic [PKT_BYTES_WIDTH-1:0] pkt_bytes;
    logic [PKT_BYTES_WIDTH-1:0] pkt_total;

    // Valid bytes in the incoming beat
    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < EGR_DATA_BYTES; i++) begin
            beat_bytes = beat_bytes + PKT_BYTES_WIDTH'(dmx_keep[i]);
        end
    end

    //////////////////////////////////////////////////
    // Admission decision
    assign free_cnt  = (BUF_ADDR_WIDTH + 1)'(BUF_DEPTH) - count;
    assign room_ok   = free_cnt >= (BUF_ADDR_WIDTH + 1)'(MTU_BEATS);
    assign drop_now  = dmx_first ? !(port_enable && room_ok) : dropping;
    assign wr_en     = dmx_valid && !drop_now;
    assign rd_en     = buf_pop && !buf_empty;
    assign buf_empty = (count == '0);
    assign pkt_total = (dmx_first ? '0 : pkt_bytes) + beat_bytes;

    assign buf_full_drop = evt_drop_full;

    always_ff @(posedge egr_bus) begin
        if (rst) begin
            wr_ptr            <= '0;
            rd_ptr            <= '0;
            count             <= '0;
            dropping          <= 1'b0;
            evt_sent          <= 1'b0;
            evt_drop_full     <= 1'b0;
            evt_drop_disabled <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + BUF_ADDR_WIDTH'(1);
            if (rd_en) rd_ptr <= rd_ptr + BUF_ADDR_WIDTH'(1);
            count <= count + (BUF_ADDR_WIDTH + 1)'(wr_en) - (BUF_ADDR_WIDTH + 1)'(rd_en);
            // Drop holds until the packet's last beat
            if (dmx_valid) dropping <= drop_now && !dmx_last;
            evt_sent          <= wr_en && dmx_last;
            evt_drop_full     <= dmx_valid && dmx_first && port_enable && !room_ok;
            evt_drop_disabled <= dmx_valid && dmx_first && !port_enable;
        end
    end

    //////////////////////////////////////////////////
    // Storage and read port
    always_ff @(posedge egr_bus) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= dmx_data;
            mem_keep[wr_ptr] <= dmx_keep;
            mem_last[wr_ptr] <= dmx_last;
            pkt_bytes        <= pkt_total;
            if (dmx_last) evt_bytes <= pkt_total;
        end
        if (rd_en) begin
            buf_data <= mem_data[rd_ptr];
            buf_keep <= mem_keep[rd_ptr];
            buf_last <= mem_last[rd_ptr];
        end
    end

endmodule

// File: design/egress_port_counters.sv
// Per-port statistics counters

`timescale 1ns/1ns

module egress_port_counters
    import egress_pkg::*;
(
    input  logic                       egr_bus,
    input  logic                       rst,
    input  logic                       cnts_clear,
    input  logic                       evt_sent,
    input  logic [PKT_BYTES_WIDTH-1:0] evt_bytes,
    input  logic                       evt_drop_full,
    input  logic                       evt_drop_disabled,
    output logic [EGR_CNT_WIDTH-1:0]   cnts [NUM_EGR_CNTS]
);

    logic [EGR_CNT_WIDTH-1:0] incr [NUM_EGR_CNTS];

    // Amount added to each counter this cycle
    always_comb begin
        incr[CNT_PKTS_SENT]     = EGR_CNT_WIDTH'(evt_sent);
        incr[CNT_BYTES_SENT]    = '0;
        incr[CNT_DROP_FULL]     = EGR_CNT_WIDTH'(evt_drop_full);
        incr[CNT_DROP_DISABLED] = EGR_CNT_WIDTH'(evt_drop_disabled);
        if (evt_sent) begin
            incr[CNT_BYTES_SENT] = EGR_CNT_WIDTH'(evt_bytes);
        end
    end

    //////////////////////////////////////////////////
    // Counters wrap on overflow
    always_ff @(posedge egr_bus) begin
        if (rst) begin
            for (int i = 0; i < NUM_EGR_CNTS; i++) begin
                cnts[i] <= '0;
            end
        end else if (cnts_clear) begin
            // Clear beats a same-cycle event
            for (int i = 0; i < NUM_EGR_CNTS; i++) begin
                cnts[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_EGR_CNTS; i++) begin
                cnts[i] <= cnts[i] + incr[i];
            end
        end
    end

endmodule

// File: design/egress_subsystem.sv
// Egress subsystem top level

`timescale 1ns/1ns

module egress_subsystem
    import egress_pkg::*;
(
    input  logic                       egr_bus,
    input  logic                       rst,
    input  logic                       egr_tvalid,
    input  logic [EGR_DATA_WIDTH-1:0]  egr_tdata,
    input  logic [EGR_DATA_BYTES-1:0]  egr_tkeep,
    input  logic                       egr_tlast,
    input  logic [PORT_SEL_WIDTH-1:0]  egr_tuser,
    input  logic [NUM_EGR_PORTS-1:0]   egr_port_enable,
    input  logic [NUM_EGR_PORTS-1:0]   egr_cnts_clear,
    output logic                       egr_tready,
    output logic [NUM_EGR_PORTS-1:0]   port_tvalid,
    output logic [PORT_DATA_WIDTH-1:0] port_tdata [NUM_EGR_PORTS],
    output logic [PORT_DATA_BYTES-1:0] port_tkeep [NUM_EGR_PORTS],
    output logic [NUM_EGR_PORTS-1:0]   port_tlast,
    output logic [EGR_CNT_WIDTH-1:0]   egr_cnts [NUM_EGR_PORTS][NUM_EGR_CNTS],
    output logic [NUM_EGR_PORTS-1:0]   egr_buf_full_drop
);

    logic [NUM_EGR_PORTS-1:0]  dmx_valid;
    logic                      dmx_first;
    logic [EGR_DATA_WIDTH-1:0] dmx_data;
    logic [EGR_DATA_BYTES-1:0] dmx_keep;
    logic                      dmx_last;

    //////////////////////////////////////////////////
    // Input side
    egress_demux u_demux (
        .egr_bus    (egr_bus),
        .rst        (rst),
        .egr_tvalid (egr_tvalid),
        .egr_tdata  (egr_tdata),
        .egr_tkeep  (egr_tkeep),
        .egr_tlast  (egr_tlast),
        .egr_tuser  (egr_tuser),
        .egr_tready (egr_tready),
        .dmx_valid  (dmx_valid),
        .dmx_first  (dmx_first),
        .dmx_data   (dmx_data),
        .dmx_keep   (dmx_keep),
        .dmx_last   (dmx_last)
    );

    //////////////////////////////////////////////////
    // One slice per physical port
    for (genvar g = 0; g < NUM_EGR_PORTS; g++) begin : g_port
        logic                       buf_pop;
        logic                       buf_empty;
        logic [EGR_DATA_WIDTH-1:0]  buf_data;
        logic [EGR_DATA_BYTES-1:0]  buf_keep;
        logic                       buf_last;
        logic                       evt_sent;
        logic [PKT_BYTES_WIDTH-1:0] evt_bytes;
        logic                       evt_drop_full;
        logic                       evt_drop_disabled;

        egress_port_buffer u_buffer (
            .egr_bus (egr_bus), .rst (rst), .port_enable (egr_port_enable[g]),
            .dmx_valid (dmx_valid[g]), .dmx_first (dmx_first), .dmx_data (dmx_data),
            .dmx_keep (dmx_keep), .dmx_last (dmx_last), .buf_pop (buf_pop),
            .buf_empty (buf_empty), .buf_data (buf_data), .buf_keep (buf_keep),
            .buf_last (buf_last), .evt_sent (evt_sent), .evt_bytes (evt_bytes),
            .evt_drop_full (evt_drop_full), .evt_drop_disabled (evt_drop_disabled),
            .buf_full_drop (egr_buf_full_drop[g])
        );

        egress_port_counters u_counters (
            .egr_bus (egr_bus), .rst (rst), .cnts_clear (egr_cnts_clear[g]),
            .evt_sent (evt_sent), .evt_bytes (evt_bytes), .evt_drop_full (evt_drop_full),
            .evt_drop_disabled (evt_drop_disabled), .cnts (egr_cnts[g])
        );

        egress_width_adapter u_adapter (
            .egr_bus (egr_bus), .rst (rst), .buf_empty (buf_empty), .buf_data (buf_data),
            .buf_keep (buf_keep), .buf_last (buf_last), .buf_pop (buf_pop),
            .port_tvalid (port_tvalid[g]), .port_tdata (port_tdata[g]),
            .port_tkeep (port_tkeep[g]), .port_tlast (port_tlast[g])
        );
    end

endmodule

// File: design/egress_width_adapter.sv
// Beat to port word width adapter

`timescale 1ns/1ns

module egress_width_adapter
    import egress_pkg::*;
(
    input  logic                       egr_bus,
    input  logic                       rst,
    input  logic                       buf_empty,
    input  logic [EGR_DATA_WIDTH-1:0]  buf_data,
    input  logic [EGR_DATA_BYTES-1:0]  buf_keep,
    input  logic                       buf_last,
    output logic                       buf_pop,
    output logic                       port_tvalid,
    output logic [PORT_DATA_WIDTH-1:0] port_tdata,
    output logic [PORT_DATA_BYTES-1:0] port_tkeep,
    output logic                       port_tlast
);

    logic                      pend;
    logic [WORD_CNT_WIDTH-1:0] words_left;
    logic [WORD_CNT_WIDTH-1:0] load_words;
    logic [EGR_DATA_WIDTH-1:0] data_q;
    logic [EGR_DATA_BYTES-1:0] keep_q;
    logic                      last_q;

    // Words holding at least one valid byte
    always_comb begin
        load_words = '0;
        for (int w = 0; w < WORDS_PER_BEAT; w++) begin
            load_words = load_words
                       + WORD_CNT_WIDTH'(|buf_keep[w*PORT_DATA_BYTES +: PORT_DATA_BYTES]);
        end
    end

    // Fetch the next beat while the final word goes out
    assign buf_pop = !pend && (words_left <= WORD_CNT_WIDTH'(1)) && !buf_empty;

    assign port_tvalid = (words_left != '0);
    assign port_tdata  = data_q[PORT_DATA_WIDTH-1:0];
    assign port_tkeep  = keep_q[PORT_DATA_BYTES-1:0];
    assign port_tlast  = last_q && (words_left == WORD_CNT_WIDTH'(1));

    //////////////////////////////////////////////////
    // Word sequencing
    always_ff @(posedge egr_bus) begin
        if (rst) begin
            pend       <= 1'b0;
            words_left <= '0;
        end else begin
            pend <= buf_pop;
            if (pend) begin
                words_left <= load_words;
            end else if (words_left != '0) begin
                words_left <= words_left - WORD_CNT_WIDTH'(1);
            end
        end
    end

    // Low word first, shift down after each word
    always_ff @(posedge egr_bus) begin
        if (pend) begin
            data_q <= buf_data;
            keep_q <= buf_keep;
            last_q <= buf_last;
        end else if (words_left != '0) begin
            data_q <= data_q >> PORT_DATA_WIDTH;
            keep_q <= keep_q >> PORT_DATA_BYTES;
        end
    end

endmodule

// File: list.f
design/egress_pkg.sv
design/egress_demux.sv
design/egress_port_buffer.sv
design/egress_port_counters.sv
design/egress_width_adapter.sv
design/egress_subsystem.sv
verification/egress_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the egress testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module egress_tb -o egress_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/egress_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: verification/egress_tb.sv
// Egress subsystem directed testbench

`timescale 1ns/1ns

module egress_tb
    import egress_pkg::*;
();

    localparam int SEED       = 49055;
    localparam int WAIT_LIMIT = 3000;

    logic                       egr_bus = 1'b0;
    logic                       rst;
    logic                       egr_tvalid;
    logic [EGR_DATA_WIDTH-1:0]  egr_tdata;
    logic [EGR_DATA_BYTES-1:0]  egr_tkeep;
    logic                       egr_tlast;
    logic [PORT_SEL_WIDTH-1:0]  egr_tuser;
    logic [NUM_EGR_PORTS-1:0]   egr_port_enable;
    logic [NUM_EGR_PORTS-1:0]   egr_cnts_clear;
    logic                       egr_tready;
    logic [NUM_EGR_PORTS-1:0]   port_tvalid;
    logic [PORT_DATA_WIDTH-1:0] port_tdata [NUM_EGR_PORTS];
    logic [PORT_DATA_BYTES-1:0] port_tkeep [NUM_EGR_PORTS];
    logic [NUM_EGR_PORTS-1:0]   port_tlast;
    logic [EGR_CNT_WIDTH-1:0]   egr_cnts [NUM_EGR_PORTS][NUM_EGR_CNTS];
    logic [NUM_EGR_PORTS-1:0]   egr_buf_full_drop;

    // Scoreboard: expected packets per port, filled by the driver
    logic [7:0] exp_bytes [NUM_EGR_PORTS][$];
    int         exp_len   [NUM_EGR_PORTS][$];
    bit         loose     [NUM_EGR_PORTS];
    int         rx_idx    [NUM_EGR_PORTS];
    int         rx_pos    [NUM_EGR_PORTS];
    int         matched   [NUM_EGR_PORTS];
    int         acc_bytes [NUM_EGR_PORTS];
    // Received packets, filled by the monitor
    logic [7:0] cur_bytes [NUM_EGR_PORTS][$];
    logic [7:0] rx_bytes  [NUM_EGR_PORTS][$];
    int         rx_len    [NUM_EGR_PORTS][$];
    logic [1:0] rx_keep   [NUM_EGR_PORTS][$];
    int         drop_pulses [NUM_EGR_PORTS];
    int         errors;
    int         fmt_errors;
    int         timeouts;

    always #5 egr_bus = !egr_bus;

    egress_subsystem UUT (
        .egr_bus (egr_bus), .rst (rst), .egr_tvalid (egr_tvalid), .egr_tdata (egr_tdata),
        .egr_tkeep (egr_tkeep), .egr_tlast (egr_tlast), .egr_tuser (egr_tuser),
        .egr_port_enable (egr_port_enable), .egr_cnts_clear (egr_cnts_clear),
        .egr_tready (egr_tready), .port_tvalid (port_tvalid), .port_tdata (port_tdata),
        .port_tkeep (port_tkeep), .port_tlast (port_tlast), .egr_cnts (egr_cnts),
        .egr_buf_full_drop (egr_buf_full_drop)
    );

    //////////////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    always @(negedge egr_bus) begin
        if (!rst) begin
            for (int p = 0; p < NUM_EGR_PORTS; p++) begin
                if (egr_buf_full_drop[p]) drop_pulses[p]++;
                if (port_tvalid[p]) begin
                    // Only an odd final byte may leave the high byte empty
                    if (port_tkeep[p] != 2'b11 && !(port_tkeep[p] == 2'b01 && port_tlast[p])) begin
                        $display("error port_tkeep[%0d] expected %h got %h",
                                 p, 2'b11, port_tkeep[p]);
                        fmt_errors++;
                    end
                    cur_bytes[p].push_back(port_tdata[p][7:0]);
                    if (port_tkeep[p][1]) cur_bytes[p].push_back(port_tdata[p][15:8]);
                    if (port_tlast[p]) begin
                        rx_len[p].push_back(cur_bytes[p].size());
                        rx_keep[p].push_back(port_tkeep[p]);
                        while (cur_bytes[p].size() > 0) begin
                            rx_bytes[p].push_back(cur_bytes[p].pop_front());
                        end
                    end
                end
            end
        end
    end

    // Pops the expected front packet and compares it with the next received one
    task automatic compare_front(input int p, input int n, input bit report, output bit ok);
        int         m;
        logic [7:0] e;
        m  = exp_len[p].pop_front();
        ok = (m == n);
        if (!ok && report) begin
            $display("error port_tlast[%0d] packet length expected %h got %h", p, m, n);
        end
        for (int i = 0; i < m; i++) begin
            e = exp_bytes[p].pop_front();
            if (i < n && e != rx_bytes[p][rx_pos[p] + i]) begin
                if (report && ok) begin
                    $display("error port_tdata[%0d] byte %0d expected %h got %h",
                             p, i, e, rx_bytes[p][rx_pos[p] + i]);
                end
                ok = 1'b0;
            end
        end
    endtask

    task automatic check_received();
        int n;
        bit ok;
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            while (rx_idx[p] < rx_len[p].size()) begin
                n  = rx_len[p][rx_idx[p]];
                ok = 1'b0;
                if (exp_len[p].size() == 0) begin
                    $display("Port %0d sent a packet that was not expected", p);
                    errors++;
                end else if (!loose[p]) begin
                    compare_front(p, n, 1'b1, ok);
                    if (!ok) errors++;
                end else begin
                    // Dropped candidates are skipped
                    while (!ok && exp_len[p].size() > 0) compare_front(p, n, 1'b0, ok);
                    if (!ok) begin
                        $display("Port %0d sent a packet that matches none that was sent in", p);
                        errors++;
                    end
                end
                if (ok) begin
                    matched[p]++;
                    acc_bytes[p] += n;
                end
                rx_pos[p] += n;
                rx_idx[p]++;
            end
        end
    endtask

    task automatic step();
        @(posedge egr_bus);
        #1;
        check_received();
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int p = 0; p < NUM_EGR_PORTS; p++) n += exp_len[p].size();
        return n;
    endfunction

    function automatic int event_total(input int p);
        return egr_cnts[p][CNT_PKTS_SENT] + egr_cnts[p][CNT_DROP_FULL]
             + egr_cnts[p][CNT_DROP_DISABLED];
    endfunction

    task automatic wait_drain();
        int t;
        t = 0;
        while (pending() != 0 && t < WAIT_LIMIT) begin
            step();
            t++;
        end
        if (pending() != 0) begin
            $display("Timeout: %0d expected packets never came out", pending());
            timeouts++;
        end
    endtask

    task automatic wait_events(input int p, input int target);
        int t;
        t = 0;
        while (event_total(p) != target && t < WAIT_LIMIT) begin
            step();
            t++;
        end
        if (event_total(p) != target) begin
            $display("Timeout: port %0d never counted its packet decisions", p);
            timeouts++;
        end
    endtask

    task automatic wait_matched(input int p, input int target);
        int t;
        t = 0;
        while (matched[p] < target && t < WAIT_LIMIT) begin
            step();
            t++;
        end
        if (matched[p] < target) begin
            $display("Timeout: port %0d did not send out all admitted packets", p);
            timeouts++;
        end
    endtask

    task automatic check_cnt(input int p, input int idx, input int expv);
        if (egr_cnts[p][idx] != expv) begin
            $display("error egr_cnts[%0d][%0d] expected %h got %h",
                     p, idx, expv, egr_cnts[p][idx]);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    task automatic send_packet(input int port, input int nbytes);
        int         nbeats;
        bit         admit;
        logic [7:0] b;
        nbeats = (nbytes + EGR_DATA_BYTES - 1) / EGR_DATA_BYTES;
        // Buffers are drained between tests, so only the enable decides
        admit  = egr_port_enable[port] || loose[port];
        if (admit) exp_len[port].push_back(nbytes);
        for (int i = 0; i < nbeats; i++) begin
            step();
            if (!egr_tready) begin
                $display("egr_tready was low while a packet was being sent");
                errors++;
            end
            egr_tvalid = 1'b1;
            egr_tdata  = '0;
            egr_tkeep  = '0;
            egr_tlast  = (i == nbeats - 1);
            egr_tuser  = (i == 0) ? PORT_SEL_WIDTH'(port) : PORT_SEL_WIDTH'($urandom);
            for (int j = 0; j < EGR_DATA_BYTES; j++) begin
                if (i * EGR_DATA_BYTES + j < nbytes) begin
                    b = 8'($urandom);
                    egr_tdata[j*8 +: 8] = b;
                    egr_tkeep[j] = 1'b1;
                    if (admit) exp_bytes[port].push_back(b);
                end
            end
        end
    endtask

    task automatic end_input();
        step();
        egr_tvalid = 1'b0;
        egr_tlast  = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    task automatic test_routing();
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            send_packet(p, 1 + int'($urandom % (MTU_BEATS * EGR_DATA_BYTES)));
            end_input();
            wait_drain();
        end
    endtask

    task automatic test_partial();
        int         beats [3] = '{1, 3, 8};
        int         nbytes;
        logic [1:0] want;
        for (int k = 0; k < 3; k++) begin
            nbytes = (beats[k] - 1) * EGR_DATA_BYTES + 5;
            want   = (nbytes % 2 == 1) ? 2'b01 : 2'b11;
            send_packet(k, nbytes);
            end_input();
            wait_drain();
            if (rx_keep[k].size() > 0 && rx_keep[k][rx_keep[k].size() - 1] != want) begin
                $display("error port_tkeep[%0d] final word expected %h got %h",
                         k, want, rx_keep[k][rx_keep[k].size() - 1]);
                errors++;
            end
        end
    endtask

    task automatic test_disabled();
        int snap [NUM_EGR_CNTS];
        int target;
        for (int i = 0; i < NUM_EGR_CNTS; i++) snap[i] = egr_cnts[3][i];
        target = event_total(3) + 1;
        egr_port_enable = 4'b0111;
        send_packet(3, 20);
        end_input();
        wait_events(3, target);
        for (int i = 0; i < NUM_EGR_CNTS; i++) begin
            check_cnt(3, i, snap[i] + ((i == CNT_DROP_DISABLED) ? 1 : 0));
        end
        egr_port_enable = 4'b1111;
    endtask

    task automatic test_overflow();
        int base_sent;
        int base_drop;
        int base_pulse;
        int base_match;
        int target;
        int sent_d;
        int drop_d;
        base_sent  = egr_cnts[2][CNT_PKTS_SENT];
        base_drop  = egr_cnts[2][CNT_DROP_FULL];
        base_pulse = drop_pulses[2];
        base_match = matched[2];
        target     = event_total(2) + 6;
        loose[2]   = 1'b1;
        repeat (6) send_packet(2, MTU_BEATS * EGR_DATA_BYTES);
        end_input();
        wait_events(2, target);
        sent_d = egr_cnts[2][CNT_PKTS_SENT] - base_sent;
        drop_d = egr_cnts[2][CNT_DROP_FULL] - base_drop;
        wait_matched(2, base_match + sent_d);
        loose[2] = 1'b0;
        exp_len[2].delete();
        exp_bytes[2].delete();
        if (sent_d + drop_d != 6) begin
            $display("error egr_cnts[2] sent plus dropped expected %h got %h", 6, sent_d + drop_d);
            errors++;
        end
        if (drop_pulses[2] - base_pulse != drop_d) begin
            $display("error egr_buf_full_drop[2] pulses expected %h got %h",
                     drop_d, drop_pulses[2] - base_pulse);
            errors++;
        end
        if (drop_d == 0) begin
            $display("No buffer-full drop was seen on port 2");
            errors++;
        end
    endtask

    task automatic test_counters();
        int snap [NUM_EGR_PORTS][NUM_EGR_CNTS];
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            check_cnt(p, CNT_BYTES_SENT, acc_bytes[p]);
            check_cnt(p, CNT_PKTS_SENT, matched[p]);
            for (int i = 0; i < NUM_EGR_CNTS; i++) snap[p][i] = egr_cnts[p][i];
        end
        // Clear lands one cycle after the pulse
        egr_cnts_clear = 4'b0010;
        step();
        egr_cnts_clear = 4'b0000;
        step();
        for (int p = 0; p < NUM_EGR_PORTS; p++) begin
            for (int i = 0; i < NUM_EGR_CNTS; i++) check_cnt(p, i, (p == 1) ? 0 : snap[p][i]);
        end
    endtask

    initial begin
        rst             = 1'b1;
        egr_tvalid      = 1'b0;
        egr_tdata       = '0;
        egr_tkeep       = '0;
        egr_tlast       = 1'b0;
        egr_tuser       = '0;
        egr_port_enable = 4'b1111;
        egr_cnts_clear  = 4'b0000;
        void'($urandom(SEED));
        repeat (5) @(posedge egr_bus);
        #1;
        rst = 1'b0;
        test_routing();
        test_partial();
        test_disabled();
        test_overflow();
        test_counters();
        $display("Errors: %0d, format errors: %0d, timeouts: %0d", errors, fmt_errors, timeouts);
        if (errors + fmt_errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
